/* common/pipe_ctrl_pkg.sv */
// shared types: word, register index, instruction token, stage payloads, retire and trap records
`default_nettype none

package pipe_ctrl_pkg;

    typedef logic [31:0] word_t;    // pc or data address
    typedef logic [4:0]  reg_idx_t; // x0 never creates a hazard

    // instruction class as delivered by the decoder ahead of imem
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0, // single cycle, result forwardable
        OP_MUL    = 3'd1, // holds execute for several cycles
        OP_LOAD   = 3'd2, // result only available at the end of mem
        OP_STORE  = 3'd3,
        OP_JUMP   = 3'd4, // always redirects
        OP_BRANCH = 3'd5, // redirects only when mispredicted
        OP_ECALL  = 3'd6, // environment call, traps in mem
        OP_HALT   = 3'd7  // stops the pipe once retired
    } op_e;

    // decoded token coming back on imem_rdata
    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     mispredict; // branch went the other way than fetch assumed
        word_t    target;     // branch/jump target, or effective address for load/store
        logic     insn_fault; // fetch side fault on this token
    } insn_t;

    // fetch -> execute
    typedef struct packed {
        word_t pc;
        insn_t insn;
    } fe_ex_t;

    // execute -> memory
    typedef struct packed {
        word_t pc;
        insn_t insn;
        logic  pend_exc; // insn fault or ecall, raised once it reaches mem
    } ex_mem_t;

    typedef enum logic [2:0] {
        CAUSE_INSN_FAULT  = 3'd0,
        CAUSE_ECALL       = 3'd1,
        CAUSE_LOAD_FAULT  = 3'd2,
        CAUSE_STORE_FAULT = 3'd3,
        CAUSE_INTERRUPT   = 3'd4
    } cause_e;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
    } retire_t;

    typedef struct packed {
        word_t  epc;
        cause_e cause;
    } trap_t;

endpackage

`default_nettype wire

/* source/fetch_stage.sv */
// fetch_stage: pc register, imem request and wait, fe_ex payload from the accepted token
`default_nettype none

module fetch_stage #(
    parameter pipe_ctrl_pkg::word_t RESET_PC    = 32'h0000_0000,
    parameter pipe_ctrl_pkg::word_t TRAP_VECTOR = 32'h0000_0100
) (
    input  wire logic                   CLK,
    input  wire logic                   rst,
    input  wire logic                   pc_en,         // pc may move this cycle
    input  wire logic                   npc_sel,       // take npc instead of pc+4
    input  wire pipe_ctrl_pkg::word_t   npc,
    input  wire logic                   trap_valid,
    input  wire logic                   suppress_iren, // redirect imminent
    output pipe_ctrl_pkg::word_t        imem_addr,
    output logic                        imem_ren,
    input  wire pipe_ctrl_pkg::insn_t   imem_rdata,
    input  wire logic                   imem_busy,
    output logic                        wait_for_imem,
    output pipe_ctrl_pkg::fe_ex_t       fetch_out,
    output logic                        fetch_valid
);
    import pipe_ctrl_pkg::*;

    word_t pc; // address of the token currently requested

    // trap vector beats an execute redirect, which beats sequential flow
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            if (trap_valid) begin
                pc <= TRAP_VECTOR;
            end else if (npc_sel) begin
                pc <= npc; // jump or mispredicted branch
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign imem_addr     = pc;
    assign imem_ren      = !suppress_iren;         // held high across busy cycles
    assign wait_for_imem = imem_ren && imem_busy;  // request out, no token yet
    assign fetch_valid   = imem_ren && !imem_busy; // token accepted this cycle

    // token and its pc travel together into execute
    assign fetch_out.pc   = pc;
    assign fetch_out.insn = imem_rdata;

endmodule

`default_nettype wire

/* source/stage_reg.sv */
// stage_reg: generic pipeline register with valid bit, stall and flush
`default_nettype none

module stage_reg #(
    parameter type PAYLOAD = logic
) (
    input  wire logic    CLK,
    input  wire logic    rst,
    input  wire logic    stall,    // hold contents
    input  wire logic    flush,    // drop contents, wins over stall
    input  wire logic    in_valid,
    input  wire PAYLOAD  in_data,
    output logic         out_valid,
    output PAYLOAD       out_data
);

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            out_valid <= 1'b0; // bubble
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // payload only matters while out_valid is set
    always_ff @(posedge CLK) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hazard/hazard_unit.sv */
// hazard_unit: load-use detection, stall/flush/pc_en priority, trap decision and epc select
`default_nettype none

module hazard_unit (
    // fetch side
    input  wire pipe_ctrl_pkg::word_t    fetch_pc,
    input  wire logic                    fetch_valid,
    input  wire logic                    wait_for_imem,
    // execute side
    input  wire pipe_ctrl_pkg::fe_ex_t   ex_in,
    input  wire logic                    ex_valid,
    input  wire logic                    branch_jump,
    input  wire pipe_ctrl_pkg::word_t    target,
    input  wire logic                    ex_busy,
    // memory side
    input  wire pipe_ctrl_pkg::ex_mem_t  mem_in,
    input  wire logic                    mem_valid,
    input  wire logic                    wait_for_dmem,
    input  wire logic                    mem_exception,
    input  wire pipe_ctrl_pkg::cause_e   mem_cause,
    input  wire logic                    intr,
    // pc control
    output logic                         pc_en,
    output logic                         npc_sel,
    output pipe_ctrl_pkg::word_t         npc,
    // stage register control
    output logic                         if_ex_stall,
    output logic                         if_ex_flush,
    output logic                         ex_mem_stall,
    output logic                         ex_mem_flush,
    output logic                         suppress_iren,
    output logic                         suppress_data,
    // trap strobe
    output logic                         trap_valid,
    output pipe_ctrl_pkg::trap_t         trap
);
    import pipe_ctrl_pkg::*;

    reg_idx_t rd_m;
    reg_idx_t rs1_e;
    reg_idx_t rs2_e;
    logic     load_in_mem;
    logic     rs1_match;
    logic     rs2_match;
    logic     load_use;
    logic     halt_in_mem;
    logic     intr_take;
    logic     jump_go;
    logic     redirect;

    assign rd_m  = mem_in.insn.rd;
    assign rs1_e = ex_in.insn.rs1;
    assign rs2_e = ex_in.insn.rs2;

    // load result is not ready until mem finishes, everything else forwards
    assign load_in_mem = mem_valid && (mem_in.insn.op == OP_LOAD) && !mem_in.pend_exc;
    assign rs1_match   = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match   = (rs2_e == rd_m) && (rd_m != '0);
    assign load_use    = load_in_mem && ex_valid && (rs1_match || rs2_match);

    // a halt parks in mem for good, mem_stage blocks its second retire
    assign halt_in_mem = mem_valid && (mem_in.insn.op == OP_HALT) && !mem_in.pend_exc;

    // interrupts wait for a pending dmem access and never override an exception
    assign intr_take  = intr && !mem_exception && !wait_for_dmem && !halt_in_mem;
    assign trap_valid = mem_exception || intr_take;

    // redirect from execute only once the branch is free to move on to mem
    assign jump_go  = branch_jump && !ex_mem_stall && !load_use && !trap_valid;
    assign redirect = trap_valid || jump_go;

    assign npc_sel = jump_go;
    assign npc     = target;

    // a stall of mem stalls everything behind it
    assign ex_mem_stall = wait_for_dmem || halt_in_mem;
    assign if_ex_stall  = ex_mem_stall
                       || ((ex_busy || load_use) && !trap_valid); // trap may kill a busy mul
    // control hazards flush, a lagging fetch feeds bubbles while execute moves
    assign if_ex_flush  = redirect || (wait_for_imem && !if_ex_stall);
    // the jump itself proceeds to mem, only traps clear ex_mem
    assign ex_mem_flush = trap_valid
                       || (if_ex_stall && !ex_mem_stall); // bubble behind a held execute

    // pc moves on an accepted token with room downstream, or on any redirect
    assign pc_en = (fetch_valid && !if_ex_stall) || redirect;

    assign suppress_iren = redirect;                     // no stale request at the old pc
    assign suppress_data = mem_valid && mem_in.pend_exc; // faulting insn must not touch dmem

    // an exception owns the mem slot; on an interrupt the mem insn completes,
    // so the oldest unretired one is in execute, else at fetch
    assign trap.epc   = (mem_valid && !intr_take) ? mem_in.pc
                      : (ex_valid ? ex_in.pc : fetch_pc);
    assign trap.cause = mem_exception ? mem_cause : CAUSE_INTERRUPT;

endmodule

`default_nettype wire

/* source/exec_stage.sv */
// exec_stage: jump/branch resolution, mul busy counter, pending exception marking
`default_nettype none

module exec_stage #(
    parameter int MUL_CYCLES = 3 // cycles a mul spends in execute, at least 1
) (
    input  wire logic                    CLK,
    input  wire logic                    rst,
    input  wire pipe_ctrl_pkg::fe_ex_t   ex_in,
    input  wire logic                    ex_valid,
    input  wire logic                    ex_advance,  // execute slot changes at this edge
    output logic                         branch_jump,
    output pipe_ctrl_pkg::word_t         target,
    output logic                         ex_busy,
    output pipe_ctrl_pkg::ex_mem_t       ex_out
);
    import pipe_ctrl_pkg::*;

    localparam int CW = $clog2(MUL_CYCLES + 1);

    logic [CW-1:0] mul_cnt; // cycles the current mul has already spent here
    logic          is_fault;
    logic          is_mul;

    assign is_fault = ex_in.insn.insn_fault; // faulting token does nothing until mem

    // jumps always redirect, branches only on a wrong guess
    assign branch_jump = ex_valid && !is_fault
                      && ((ex_in.insn.op == OP_JUMP)
                      || ((ex_in.insn.op == OP_BRANCH) && ex_in.insn.mispredict));
    assign target = ex_in.insn.target;

    assign is_mul  = ex_valid && !is_fault && (ex_in.insn.op == OP_MUL);
    assign ex_busy = is_mul && (mul_cnt < CW'(MUL_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (rst) begin
            mul_cnt <= '0;
        end else if (ex_advance) begin
            mul_cnt <= '0; // fresh count for whatever enters next
        end else if (ex_busy) begin
            mul_cnt <= mul_cnt + 1'b1;
        end
    end

    // pending exception rides along and is raised by mem
    assign ex_out.pc       = ex_in.pc;
    assign ex_out.insn     = ex_in.insn;
    assign ex_out.pend_exc = is_fault || (ex_in.insn.op == OP_ECALL);

endmodule

`default_nettype wire

/* source/mem_stage.sv */
// mem_stage: dmem request and wait, fault to cause mapping, in-order retire, halted latch
`default_nettype none

module mem_stage (
    input  wire logic                    CLK,
    input  wire logic                    rst,
    input  wire pipe_ctrl_pkg::ex_mem_t  mem_in,
    input  wire logic                    mem_valid,
    input  wire logic                    suppress_data,
    output logic                         dmem_ren,
    output logic                         dmem_wen,
    output pipe_ctrl_pkg::word_t         dmem_addr,
    input  wire logic                    dmem_busy,
    input  wire logic                    dmem_fault,   // valid only in the completing cycle
    output logic                         wait_for_dmem,
    output logic                         mem_exception,
    output pipe_ctrl_pkg::cause_e        mem_cause,
    output logic                         retire_valid,
    output pipe_ctrl_pkg::retire_t       retire,
    output logic                         halted
);
    import pipe_ctrl_pkg::*;

    logic is_load;
    logic is_store;
    logic access;
    logic done_fault;
    logic live; // valid insn and the pipe is still running

    assign live     = mem_valid && !halted;
    assign is_load  = mem_in.insn.op == OP_LOAD;
    assign is_store = mem_in.insn.op == OP_STORE;
    assign access   = live && !suppress_data && (is_load || is_store);

    assign dmem_ren  = access && is_load;
    assign dmem_wen  = access && is_store;
    assign dmem_addr = mem_in.insn.target; // stands in for the effective address

    assign wait_for_dmem = access && dmem_busy;             // request held until not busy
    assign done_fault    = access && !dmem_busy && dmem_fault;

    // pending fault from fetch/execute first, then the dmem response
    assign mem_exception = live && (mem_in.pend_exc || done_fault);
    always_comb begin
        if (mem_in.pend_exc) begin
            mem_cause = mem_in.insn.insn_fault ? CAUSE_INSN_FAULT : CAUSE_ECALL;
        end else begin
            mem_cause = is_load ? CAUSE_LOAD_FAULT : CAUSE_STORE_FAULT;
        end
    end

    // one strobe per insn as it leaves, a trap takes its place on a fault
    assign retire_valid = live && !wait_for_dmem && !mem_exception;
    assign retire.pc    = mem_in.pc;
    assign retire.rd    = mem_in.insn.rd;

    always_ff @(posedge CLK) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (retire_valid && (mem_in.insn.op == OP_HALT)) begin
            halted <= 1'b1; // sticky until reset
        end
    end

endmodule

`default_nettype wire

/* source/pipe_ctrl_top.sv */
// pipe_ctrl_top: fetch, if_ex and ex_mem registers, execute, hazard unit and mem stage
`default_nettype none

module pipe_ctrl_top #(
    parameter pipe_ctrl_pkg::word_t RESET_PC    = 32'h0000_0000,
    parameter pipe_ctrl_pkg::word_t TRAP_VECTOR = 32'h0000_0100,
    parameter int                   MUL_CYCLES  = 3
) (
    input  wire logic                   CLK,
    input  wire logic                   rst,
    output pipe_ctrl_pkg::word_t        imem_addr,
    output logic                        imem_ren,
    input  wire pipe_ctrl_pkg::insn_t   imem_rdata,
    input  wire logic                   imem_busy,
    output logic                        dmem_ren,
    output logic                        dmem_wen,
    output pipe_ctrl_pkg::word_t        dmem_addr,
    input  wire logic                   dmem_busy,
    input  wire logic                   dmem_fault,
    input  wire logic                   intr,
    output logic                        retire_valid,
    output pipe_ctrl_pkg::retire_t      retire,
    output logic                        trap_valid,
    output pipe_ctrl_pkg::trap_t        trap,
    output logic                        halted
);
    import pipe_ctrl_pkg::*;

    fe_ex_t  fetch_out;
    fe_ex_t  ex_in;
    ex_mem_t ex_out;
    ex_mem_t mem_in;
    word_t   npc;
    word_t   target;
    cause_e  mem_cause;
    logic    fetch_valid, wait_for_imem, ex_valid, mem_valid;
    logic    pc_en, npc_sel, branch_jump, ex_busy;
    logic    if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic    suppress_iren, suppress_data, wait_for_dmem, mem_exception;

    fetch_stage #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) u_fetch (
        .CLK, .rst, .pc_en, .npc_sel, .npc, .trap_valid, .suppress_iren,
        .imem_addr, .imem_ren, .imem_rdata, .imem_busy,
        .wait_for_imem, .fetch_out, .fetch_valid
    );

    stage_reg #(.PAYLOAD(fe_ex_t)) u_if_ex (
        .CLK, .rst, .stall(if_ex_stall), .flush(if_ex_flush),
        .in_valid(fetch_valid), .in_data(fetch_out),
        .out_valid(ex_valid), .out_data(ex_in)
    );

    // execute slot turns over whenever if_ex loads or is flushed
    exec_stage #(.MUL_CYCLES(MUL_CYCLES)) u_exec (
        .CLK, .rst, .ex_in, .ex_valid, .ex_advance(!if_ex_stall || if_ex_flush),
        .branch_jump, .target, .ex_busy, .ex_out
    );

    stage_reg #(.PAYLOAD(ex_mem_t)) u_ex_mem (
        .CLK, .rst, .stall(ex_mem_stall), .flush(ex_mem_flush),
        .in_valid(ex_valid), .in_data(ex_out),
        .out_valid(mem_valid), .out_data(mem_in)
    );

    hazard_unit u_hazard (
        .fetch_pc(imem_addr), .fetch_valid, .wait_for_imem,
        .ex_in, .ex_valid, .branch_jump, .target, .ex_busy,
        .mem_in, .mem_valid, .wait_for_dmem, .mem_exception, .mem_cause, .intr,
        .pc_en, .npc_sel, .npc,
        .if_ex_stall, .if_ex_flush, .ex_mem_stall, .ex_mem_flush,
        .suppress_iren, .suppress_data, .trap_valid, .trap
    );

    mem_stage u_mem (
        .CLK, .rst, .mem_in, .mem_valid, .suppress_data,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_busy, .dmem_fault,
        .wait_for_dmem, .mem_exception, .mem_cause,
        .retire_valid, .retire, .halted
    );

endmodule

`default_nettype wire

/* tb/pipe_ctrl_tb.sv */
// pipe_ctrl_tb: clock, reset, imem/dmem models, reference walker, directed tests, compares, watchdog
`default_nettype none

module pipe_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pipe_ctrl_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam word_t TRAP_VECTOR = 32'h0000_0100;
    localparam int    MUL_CYCLES  = 3;
    localparam word_t NO_FAULT    = 32'hffff_fffc; // no program touches this address
    localparam int    PROG_INSNS  = 96; // all test programs together, incl. handlers
    localparam int    BUSY_MARGIN = 16; // cycles per insn with busy memories, mul and resets

    logic    clk;
    logic    rst;
    word_t   imem_addr;
    logic    imem_ren;
    insn_t   imem_rdata;
    logic    imem_busy;
    logic    dmem_ren;
    logic    dmem_wen;
    word_t   dmem_addr;
    logic    dmem_busy;
    logic    dmem_fault;
    logic    intr;
    logic    retire_valid;
    retire_t retire;
    logic    trap_valid;
    trap_t   trap;
    logic    halted;

    insn_t   imem [word_t];  // sparse program store
    retire_t exp_retire[$];  // filled by the walker
    trap_t   exp_trap[$];
    word_t   fault_addr;     // dmem address that answers with a fault
    logic    busy_on;        // random back-pressure on both memories
    logic    intr_armed;     // one interrupt trap still expected
    integer  seed;
    int      n_err;
    int      n_chk;

    pipe_ctrl_top #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR), .MUL_CYCLES(MUL_CYCLES)) DUT (
        .CLK(clk), .rst, .imem_addr, .imem_ren, .imem_rdata, .imem_busy,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_busy, .dmem_fault, .intr,
        .retire_valid, .retire, .trap_valid, .trap, .halted
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic insn_t mk(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                 input reg_idx_t rs2, input word_t tgt, input logic mp,
                                 input logic flt);
        insn_t t;
        t.op         = op;
        t.rd         = rd;
        t.rs1        = rs1;
        t.rs2        = rs2;
        t.mispredict = mp;
        t.target     = tgt;
        t.insn_fault = flt;
        return t;
    endfunction

    // unwritten addresses read as a harmless alu op with rd x0
    function automatic insn_t fetch_token(input word_t a);
        if (imem.exists(a)) begin
            return imem[a];
        end
        return mk(OP_ALU, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
    endfunction

    // memory models, all inputs move 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        imem_rdata = fetch_token(imem_addr); // pc is registered, stable here
        imem_busy  = busy_on && (($random(seed) & 3) == 0);
        dmem_busy  = busy_on && (($random(seed) & 3) == 0);
        dmem_fault = (dmem_addr == fault_addr); // only looked at in the completing cycle
    end

    // architectural walk of the program: in order, redirects taken, traps to the vector
    task automatic walk(input word_t start);
        word_t   pc;
        insn_t   t;
        retire_t r;
        trap_t   x;
        int      steps;
        logic    done;
        pc    = start;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 64) begin
            t     = fetch_token(pc);
            r.pc  = pc;
            r.rd  = t.rd;
            x.epc = pc;
            steps++;
            if (t.insn_fault || t.op == OP_ECALL) begin
                x.cause = t.insn_fault ? CAUSE_INSN_FAULT : CAUSE_ECALL;
                exp_trap.push_back(x);
                pc = TRAP_VECTOR;
            end else if ((t.op == OP_LOAD || t.op == OP_STORE) && t.target == fault_addr) begin
                x.cause = (t.op == OP_LOAD) ? CAUSE_LOAD_FAULT : CAUSE_STORE_FAULT;
                exp_trap.push_back(x);
                pc = TRAP_VECTOR;
            end else begin
                exp_retire.push_back(r);
                if (t.op == OP_HALT) begin
                    done = 1'b1;
                end else if (t.op == OP_JUMP || (t.op == OP_BRANCH && t.mispredict)) begin
                    pc = t.target;
                end else begin
                    pc = pc + 32'd4;
                end
            end
        end
    endtask

    task automatic check_retire(input retire_t got);
        retire_t exp;
        n_chk++;
        if (exp_retire.size() == 0) begin
            n_err++;
            $display("unexpected retire at %0t: pc %h rd %0d", $time, got.pc, got.rd);
        end else begin
            exp = exp_retire.pop_front();
            if (got !== exp) begin
                n_err++;
                $display("FAILED at %0t: retire pc %h rd %0d, expected pc %h rd %0d",
                         $time, got.pc, got.rd, exp.pc, exp.rd);
            end
        end
    endtask

    task automatic check_trap(input trap_t got);
        trap_t exp;
        n_chk++;
        if (exp_trap.size() == 0) begin
            n_err++;
            $display("unexpected trap at %0t: epc %h cause %s", $time, got.epc, got.cause.name());
        end else begin
            exp = exp_trap.pop_front();
            if (got !== exp) begin
                n_err++;
                $display("FAILED at %0t: trap epc %h %s, expected epc %h %s", $time,
                         got.epc, got.cause.name(), exp.epc, exp.cause.name());
            end
        end
    endtask

    // insn leaving mem: a clean load or store completes its access this cycle, others touch nothing
    task automatic check_dmem(input insn_t t);
        logic exp_ren;
        logic exp_wen;
        exp_ren = (t.op == OP_LOAD) && !t.insn_fault;
        exp_wen = (t.op == OP_STORE) && !t.insn_fault;
        n_chk++;
        if (dmem_ren !== exp_ren || dmem_wen !== exp_wen
                || ((exp_ren || exp_wen) && dmem_addr !== t.target)) begin
            n_err++;
            $display("FAILED at %0t: dmem ren %b wen %b addr %h, expected ren %b wen %b addr %h",
                     $time, dmem_ren, dmem_wen, dmem_addr, exp_ren, exp_wen, t.target);
        end
    endtask

    // fetch must not request while a trap redirects it
    task automatic check_fetch_quiet();
        n_chk++;
        if (imem_ren !== 1'b0) begin
            n_err++;
            $display("FAILED at %0t: imem_ren %b during a trap, expected 0", $time, imem_ren);
        end
    endtask

    // oldest unretired insn is the head of the walk; afterwards the handler runs
    task automatic expect_interrupt();
        trap_t x;
        x.epc   = (exp_retire.size() > 0) ? exp_retire[0].pc : '1;
        x.cause = CAUSE_INTERRUPT;
        exp_retire.delete();
        walk(TRAP_VECTOR);
        exp_trap.push_back(x);
        intr_armed = 1'b0;
    endtask

    // outputs sampled mid cycle, retire before trap since both can fire on an interrupt
    always @(negedge clk) begin
        if (!rst) begin
            if (retire_valid) begin
                check_retire(retire);
                check_dmem(fetch_token(retire.pc));
            end
            if (trap_valid) begin
                check_fetch_quiet();
                if (intr_armed) begin
                    expect_interrupt();
                end
                if (trap.cause != CAUSE_INTERRUPT) begin
                    check_dmem(fetch_token(trap.epc));
                end
                check_trap(trap);
            end
        end
    end

    task automatic run_program(input logic busy);
        exp_retire.delete();
        exp_trap.delete();
        walk(RESET_PC);
        busy_on = busy;
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        while (!halted) @(negedge clk);
        repeat (4) @(negedge clk); // a retire after the halt would show here
        if (exp_retire.size() != 0 || exp_trap.size() != 0) begin
            n_err++;
            $display("at %0t: halted with %0d retires and %0d traps still expected",
                     $time, exp_retire.size(), exp_trap.size());
        end
        busy_on = 1'b0;
    endtask

    task automatic test_alu_sequence();
        int i;
        imem.delete();
        for (i = 0; i < 6; i++) begin
            imem[word_t'(4 * i)] = mk(OP_ALU, reg_idx_t'(i + 1), reg_idx_t'(i), 5'd0, '0, 1'b0, 1'b0);
        end
        imem[32'h18] = mk(OP_HALT, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        run_program(1'b0);
    endtask

    task automatic test_load_use();
        imem.delete();
        imem[32'h00] = mk(OP_LOAD, 5'd5, 5'd0, 5'd0, 32'h800, 1'b0, 1'b0);
        imem[32'h04] = mk(OP_ALU, 5'd6, 5'd5, 5'd0, '0, 1'b0, 1'b0); // rs1 waits on the load
        imem[32'h08] = mk(OP_ALU, 5'd7, 5'd0, 5'd5, '0, 1'b0, 1'b0);
        imem[32'h0c] = mk(OP_LOAD, 5'd8, 5'd6, 5'd0, 32'h804, 1'b0, 1'b0);
        imem[32'h10] = mk(OP_ALU, 5'd9, 5'd8, 5'd6, '0, 1'b0, 1'b0);
        imem[32'h14] = mk(OP_STORE, 5'd0, 5'd9, 5'd8, 32'h808, 1'b0, 1'b0);
        imem[32'h18] = mk(OP_HALT, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        run_program(1'b0);
    endtask

    // jump, mul, load, mispredicted and correctly predicted branch
    task automatic test_redirects(input logic busy);
        imem.delete();
        imem[32'h00] = mk(OP_ALU, 5'd1, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h04] = mk(OP_JUMP, 5'd0, 5'd0, 5'd0, 32'h40, 1'b0, 1'b0);
        imem[32'h08] = mk(OP_ALU, 5'd2, 5'd0, 5'd0, '0, 1'b0, 1'b0);  // shadow of the jump
        imem[32'h0c] = mk(OP_ALU, 5'd3, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h40] = mk(OP_MUL, 5'd3, 5'd1, 5'd1, '0, 1'b0, 1'b0);
        imem[32'h44] = mk(OP_LOAD, 5'd4, 5'd3, 5'd0, 32'h800, 1'b0, 1'b0);
        imem[32'h48] = mk(OP_ALU, 5'd5, 5'd4, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h4c] = mk(OP_BRANCH, 5'd0, 5'd5, 5'd0, 32'h80, 1'b1, 1'b0);
        imem[32'h50] = mk(OP_ALU, 5'd6, 5'd0, 5'd0, '0, 1'b0, 1'b0);  // wrong path
        imem[32'h54] = mk(OP_ALU, 5'd7, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h80] = mk(OP_BRANCH, 5'd0, 5'd5, 5'd0, 32'h200, 1'b0, 1'b0); // falls through
        imem[32'h84] = mk(OP_STORE, 5'd0, 5'd0, 5'd5, 32'h804, 1'b0, 1'b0);
        imem[32'h88] = mk(OP_HALT, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        run_program(busy);
    endtask

    task automatic load_handler();
        imem[TRAP_VECTOR]         = mk(OP_ALU, 5'd10, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[TRAP_VECTOR + 32'd4] = mk(OP_HALT, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
    endtask

    task automatic test_faults();
        imem.delete();  // ecall
        load_handler();
        imem[32'h00] = mk(OP_ALU, 5'd1, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h04] = mk(OP_ECALL, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h08] = mk(OP_ALU, 5'd2, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        run_program(1'b0);
        imem.delete();  // fetch fault on a jump token
        load_handler();
        imem[32'h00] = mk(OP_ALU, 5'd1, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h04] = mk(OP_JUMP, 5'd3, 5'd0, 5'd0, 32'h40, 1'b0, 1'b1);
        imem[32'h08] = mk(OP_ALU, 5'd2, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        run_program(1'b0);
        imem.delete();  // dmem fault on a load
        load_handler();
        fault_addr   = 32'h900;
        imem[32'h00] = mk(OP_ALU, 5'd1, 5'd0, 5'd0, '0, 1'b0, 1'b0);
        imem[32'h04] = mk(OP_LOAD, 5'd4, 5'd1, 5'd0, 32'h900, 1'b0, 1'b0);
        imem[32'h08] = mk(OP_ALU, 5'd2, 5'd4, 5'd0, '0, 1'b0, 1'b0);
        run_program(1'b1);
        fault_addr = NO_FAULT;
    endtask

    task automatic test_interrupt_halt();
        int i;
        imem.delete();
        load_handler();
        for (i = 0; i < 16; i++) begin
            imem[word_t'(4 * i)] = mk(OP_ALU, reg_idx_t'(i + 1), 5'd0, 5'd0, '0, 1'b0, 1'b0);
        end
        imem[32'h40] = mk(OP_HALT, 5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0); // never reached
        intr_armed = 1'b1;
        fork
            run_program(1'b0);
            begin
                repeat (7) @(posedge clk); // a few insns in flight after reset
                #1 intr = 1'b1;
                @(posedge clk);
                #1 intr = 1'b0;
            end
        join
        if (intr_armed) begin
            n_err++;
            $display("at %0t: the interrupt pulse never caused a trap", $time);
        end
    endtask

    initial begin
        repeat (PROG_INSNS * BUSY_MARGIN) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped making progress",
                 PROG_INSNS * BUSY_MARGIN);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        intr       = 1'b0;
        imem_rdata = '0;
        imem_busy  = 1'b0;
        dmem_busy  = 1'b0;
        dmem_fault = 1'b0;
        busy_on    = 1'b0;
        intr_armed = 1'b0;
        fault_addr = NO_FAULT;
        seed       = 32'h6fb2_f01b;
        n_err      = 0;
        n_chk      = 0;
        test_alu_sequence();
        test_load_use();
        test_redirects(1'b0);
        test_redirects(1'b1); // same program under random back-pressure
        test_faults();
        test_interrupt_halt();
        $display("checks %0d, errors %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
common/pipe_ctrl_pkg.sv
source/fetch_stage.sv
source/stage_reg.sv
hazard/hazard_unit.sv
source/exec_stage.sv
source/mem_stage.sv
source/pipe_ctrl_top.sv
tb/pipe_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide on the log contents
mkdir -p build &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f project.f \
    --top-module pipe_ctrl_tb -Mdir build -o sim &&
./build/sim | tee build/sim.log &&
grep -q "^TESTS PASSED$" build/sim.log &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }
